/* icache_params.svh */
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Fetch address and data widths
`define ICACHE_ADDR_W  32
`define ICACHE_DATA_W  32
`define ICACHE_LINE_W  128

// Direct-mapped geometry, tag + index + word + byte = address width
`define ICACHE_SETS    64
`define ICACHE_INDEX_W 6
`define ICACHE_TAG_W   22
`define ICACHE_OFF_W   2
`define ICACHE_BYTE_W  2

// Backing memory, 4 KB
`define IMEM_LINES     256
`define IMEM_LINE_W    8
`define IMEM_LAT       3
`define IMEM_CNT_W     2

`endif

/* icache_pkg.sv */
`include "icache_params.svh"

package icache_pkg;

  // One fetch address word, seen whole or split into cache fields
  typedef union packed {
    logic [`ICACHE_ADDR_W-1:0] raw;
    struct packed {
      logic [`ICACHE_TAG_W-1:0]   tag;
      logic [`ICACHE_INDEX_W-1:0] index;
      logic [`ICACHE_OFF_W-1:0]   word;      // Word within the line
      logic [`ICACHE_BYTE_W-1:0]  byte_off;  // Always zero for fetches
    } fields;
  } icache_addr_u;

endpackage

/* icache_ram.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_ram (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       cache_rw_i,
  input  logic                       flush_i,
  input  logic [`ICACHE_INDEX_W-1:0] index_i,
  input  logic [`ICACHE_TAG_W-1:0]   write_tag_i,
  input  logic [`ICACHE_LINE_W-1:0]  write_cldata_i,
  input  logic                       write_valid_i,
  output logic [`ICACHE_TAG_W-1:0]   read_tag_o,
  output logic [`ICACHE_LINE_W-1:0]  read_cldata_o,
  output logic                       read_valid_o
);

  logic [`ICACHE_TAG_W-1:0]  tag_mem  [`ICACHE_SETS];
  logic [`ICACHE_LINE_W-1:0] line_mem [`ICACHE_SETS];
  logic [`ICACHE_SETS-1:0]   valid_q;

  always_ff @(posedge clk_i) begin
    if (cache_rw_i) begin
      tag_mem[index_i]  <= write_tag_i;
      line_mem[index_i] <= write_cldata_i;
      read_tag_o        <= write_tag_i;     // Write-first read
      read_cldata_o     <= write_cldata_i;
    end else begin
      read_tag_o        <= tag_mem[index_i];
      read_cldata_o     <= line_mem[index_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni || flush_i) begin
      valid_q      <= '0;
      read_valid_o <= 1'b0;
    end else if (cache_rw_i) begin
      valid_q[index_i] <= write_valid_i;
      read_valid_o     <= write_valid_i;
    end else begin
      read_valid_o <= valid_q[index_i];
    end
  end

  // Flushes are only issued while both caches are idle
  a_no_write_on_flush : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(cache_rw_i && flush_i));

endmodule

/* icache_datapath.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_datapath (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      cache_rw_i,
  input  logic                      flush_i,
  output logic                      cache_hit_o,

  // Fetch side
  input  icache_pkg::icache_addr_u  if2icache_addr_i,
  output logic [`ICACHE_DATA_W-1:0] icache2if_data_o,

  // Memory side
  input  logic [`ICACHE_LINE_W-1:0] imem2icache_data_i,
  output icache_pkg::icache_addr_u  icache2imem_addr_o
);

  logic [`ICACHE_TAG_W-1:0]  read_tag;
  logic [`ICACHE_LINE_W-1:0] read_line;
  logic                      read_valid;
  logic [`ICACHE_DATA_W-1:0] word_sel;

  // RAM output belongs to the address held since the previous edge
  assign cache_hit_o = read_valid && (read_tag == if2icache_addr_i.fields.tag);

  assign word_sel =
    read_line[if2icache_addr_i.fields.word * `ICACHE_DATA_W +: `ICACHE_DATA_W];

  always_ff @(posedge clk_i) begin
    icache2if_data_o <= word_sel;
  end

  assign icache2imem_addr_o = if2icache_addr_i;  // Memory returns the whole line

  icache_ram u_icache_ram (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cache_rw_i     (cache_rw_i),
    .flush_i        (flush_i),
    .index_i        (if2icache_addr_i.fields.index),
    .write_tag_i    (if2icache_addr_i.fields.tag),
    .write_cldata_i (imem2icache_data_i),
    .write_valid_i  (1'b1),
    .read_tag_o     (read_tag),
    .read_cldata_o  (read_line),
    .read_valid_o   (read_valid)
  );

endmodule

/* icache.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module icache (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,

  // Fetch port
  input  logic                      req_i,
  input  logic [`ICACHE_ADDR_W-1:0] addr_i,
  output logic [`ICACHE_DATA_W-1:0] rdata_o,
  output logic                      valid_o,

  // Memory port towards the arbiter
  output logic                      mem_req_o,
  output icache_pkg::icache_addr_u  mem_addr_o,
  input  logic                      mem_gnt_i,
  input  logic                      mem_rvalid_i,
  input  logic [`ICACHE_LINE_W-1:0] mem_line_i
);

  import icache_pkg::*;

  localparam logic [2:0] S_IDLE     = 3'd0;
  localparam logic [2:0] S_LOOKUP   = 3'd1;
  localparam logic [2:0] S_MISS_REQ = 3'd2;
  localparam logic [2:0] S_REFILL   = 3'd3;
  localparam logic [2:0] S_RESPOND  = 3'd4;

  logic [2:0]   state_q;
  logic [2:0]   state_d;
  logic         cache_hit;
  logic         cache_rw;
  icache_addr_u fetch_addr;

  assign fetch_addr.raw = addr_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (req_i) begin
          state_d = S_LOOKUP;      // RAM reads the held index on this edge
        end
      end
      S_LOOKUP: begin
        state_d = cache_hit ? S_RESPOND : S_MISS_REQ;
      end
      S_MISS_REQ: begin
        if (mem_gnt_i) begin
          state_d = S_REFILL;
        end
      end
      S_REFILL: begin
        if (mem_rvalid_i) begin
          state_d = S_LOOKUP;      // Re-read the refilled line
        end
      end
      S_RESPOND: begin
        state_d = S_IDLE;
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign cache_rw  = (state_q == S_REFILL) && mem_rvalid_i;
  assign mem_req_o = (state_q == S_MISS_REQ);
  assign valid_o   = (state_q == S_RESPOND);

  icache_datapath u_icache_datapath (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .cache_rw_i         (cache_rw),
    .flush_i            (flush_i),
    .cache_hit_o        (cache_hit),
    .if2icache_addr_i   (fetch_addr),
    .icache2if_data_o   (rdata_o),
    .imem2icache_data_i (mem_line_i),
    .icache2imem_addr_o (mem_addr_o)
  );

  // A response needs a request held for at least two edges
  a_valid_needs_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni) $rose(valid_o) |-> req_i && $past(req_i));

endmodule

/* imem_arbiter.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module imem_arbiter (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      req0_i,
  input  icache_pkg::icache_addr_u  addr0_i,
  output logic                      gnt0_o,
  output logic                      rvalid0_o,

  input  logic                      req1_i,
  input  icache_pkg::icache_addr_u  addr1_i,
  output logic                      gnt1_o,
  output logic                      rvalid1_o,

  output logic [`ICACHE_LINE_W-1:0] line_o,

  output logic                      rd_en_o,
  output icache_pkg::icache_addr_u  rd_addr_o,
  input  logic [`ICACHE_LINE_W-1:0] rd_line_i,
  input  logic                      rd_valid_i
);

  logic busy_q;
  logic owner_q;   // Port of the read in flight
  logic last_q;    // Port served last
  logic pick1;
  logic start;

  assign pick1 = req1_i && (!req0_i || !last_q);
  assign start = !busy_q && (req0_i || req1_i);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
      last_q  <= 1'b1;   // Port 0 wins the first tie
      gnt0_o  <= 1'b0;
      gnt1_o  <= 1'b0;
      rd_en_o <= 1'b0;
    end else begin
      gnt0_o  <= start && !pick1;
      gnt1_o  <= start && pick1;
      rd_en_o <= start;
      if (start) begin
        busy_q  <= 1'b1;
        owner_q <= pick1;
        last_q  <= pick1;
      end else if (rd_valid_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      rd_addr_o.raw <= pick1 ? addr1_i.raw : addr0_i.raw;
    end
  end

  assign rvalid0_o = rd_valid_i && !owner_q;
  assign rvalid1_o = rd_valid_i && owner_q;
  assign line_o    = rd_line_i;   // Shared bus, rvalid tells the owner

  a_one_grant : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(gnt0_o && gnt1_o));

endmodule

/* imem.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module imem (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // Word load port
  input  logic                      load_we_i,
  input  icache_pkg::icache_addr_u  load_addr_i,
  input  logic [`ICACHE_DATA_W-1:0] load_data_i,

  // Line read port
  input  logic                      rd_en_i,
  input  icache_pkg::icache_addr_u  rd_addr_i,
  output logic [`ICACHE_LINE_W-1:0] rd_line_o,
  output logic                      rd_valid_o
);

  logic [`ICACHE_LINE_W-1:0] mem [`IMEM_LINES];
  logic [`IMEM_LINE_W-1:0]   load_line;
  logic [`IMEM_LINE_W-1:0]   rd_line_num;
  logic [`IMEM_LINE_W-1:0]   rd_line_q;
  logic [`IMEM_CNT_W-1:0]    cnt_q;

  // Upper tag bits fall outside the 4 KB array
  assign load_line   = {load_addr_i.fields.tag[`IMEM_LINE_W-`ICACHE_INDEX_W-1:0],
                        load_addr_i.fields.index};
  assign rd_line_num = {rd_addr_i.fields.tag[`IMEM_LINE_W-`ICACHE_INDEX_W-1:0],
                        rd_addr_i.fields.index};

  always_ff @(posedge clk_i) begin
    if (load_we_i) begin
      mem[load_line][load_addr_i.fields.word * `ICACHE_DATA_W +: `ICACHE_DATA_W] <= load_data_i;
    end
    if (rd_en_i) begin
      rd_line_q <= rd_line_num;
    end
    if (cnt_q == `IMEM_CNT_W'(1)) begin
      rd_line_o <= mem[rd_line_q];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cnt_q      <= '0;
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= (cnt_q == `IMEM_CNT_W'(1));   // IMEM_LAT after rd_en
      if (rd_en_i) begin
        cnt_q <= `IMEM_CNT_W'(`IMEM_LAT - 1);
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - `IMEM_CNT_W'(1);
      end
    end
  end

  // Arbiter must wait for the previous line
  a_no_read_while_busy : assert property (
    @(posedge clk_i) disable iff (!rst_ni) rd_en_i |-> (cnt_q == '0) && !rd_valid_o);

endmodule

/* icache_cluster.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_cluster (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,

  input  logic                      f0_req_i,
  input  logic [`ICACHE_ADDR_W-1:0] f0_addr_i,
  output logic [`ICACHE_DATA_W-1:0] f0_rdata_o,
  output logic                      f0_valid_o,

  input  logic                      f1_req_i,
  input  logic [`ICACHE_ADDR_W-1:0] f1_addr_i,
  output logic [`ICACHE_DATA_W-1:0] f1_rdata_o,
  output logic                      f1_valid_o,

  input  logic                      load_we_i,
  input  logic [`ICACHE_ADDR_W-1:0] load_addr_i,
  input  logic [`ICACHE_DATA_W-1:0] load_data_i
);

  import icache_pkg::*;

  logic                      mem_req0;
  logic                      mem_req1;
  icache_addr_u              mem_addr0;
  icache_addr_u              mem_addr1;
  logic                      mem_gnt0;
  logic                      mem_gnt1;
  logic                      mem_rvalid0;
  logic                      mem_rvalid1;
  logic [`ICACHE_LINE_W-1:0] mem_line;
  logic                      rd_en;
  icache_addr_u              rd_addr;
  logic [`ICACHE_LINE_W-1:0] rd_line;
  logic                      rd_valid;

  icache u_icache0 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .req_i        (f0_req_i),
    .addr_i       (f0_addr_i),
    .rdata_o      (f0_rdata_o),
    .valid_o      (f0_valid_o),
    .mem_req_o    (mem_req0),
    .mem_addr_o   (mem_addr0),
    .mem_gnt_i    (mem_gnt0),
    .mem_rvalid_i (mem_rvalid0),
    .mem_line_i   (mem_line)
  );

  icache u_icache1 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .req_i        (f1_req_i),
    .addr_i       (f1_addr_i),
    .rdata_o      (f1_rdata_o),
    .valid_o      (f1_valid_o),
    .mem_req_o    (mem_req1),
    .mem_addr_o   (mem_addr1),
    .mem_gnt_i    (mem_gnt1),
    .mem_rvalid_i (mem_rvalid1),
    .mem_line_i   (mem_line)
  );

  imem_arbiter u_imem_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req0_i     (mem_req0),
    .addr0_i    (mem_addr0),
    .gnt0_o     (mem_gnt0),
    .rvalid0_o  (mem_rvalid0),
    .req1_i     (mem_req1),
    .addr1_i    (mem_addr1),
    .gnt1_o     (mem_gnt1),
    .rvalid1_o  (mem_rvalid1),
    .line_o     (mem_line),
    .rd_en_o    (rd_en),
    .rd_addr_o  (rd_addr),
    .rd_line_i  (rd_line),
    .rd_valid_i (rd_valid)
  );

  imem u_imem (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .load_we_i   (load_we_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i),
    .rd_en_i     (rd_en),
    .rd_addr_i   (rd_addr),
    .rd_line_o   (rd_line),
    .rd_valid_o  (rd_valid)
  );

endmodule

/* tb_icache_cluster.sv */
`timescale 1ns/1ps
`include "icache_params.svh"

module tb_icache_cluster;

  localparam int MEM_WORDS  = `IMEM_LINES * 4;
  localparam int HIT_LAT    = 2;
  localparam int MAX_CYCLES = 20000;  // Full load plus about 400 worst-case fetches with margin

  logic                      clk_i;
  logic                      rst_ni;
  logic                      flush_i;
  logic                      f0_req_i;
  logic [`ICACHE_ADDR_W-1:0] f0_addr_i;
  logic [`ICACHE_DATA_W-1:0] f0_rdata_o;
  logic                      f0_valid_o;
  logic                      f1_req_i;
  logic [`ICACHE_ADDR_W-1:0] f1_addr_i;
  logic [`ICACHE_DATA_W-1:0] f1_rdata_o;
  logic                      f1_valid_o;
  logic                      load_we_i;
  logic [`ICACHE_ADDR_W-1:0] load_addr_i;
  logic [`ICACHE_DATA_W-1:0] load_data_i;

  logic [`ICACHE_DATA_W-1:0] mem_model [MEM_WORDS];
  logic [`ICACHE_TAG_W-1:0]  tag_model [2][`ICACHE_SETS];
  logic                      valid_model [2][`ICACHE_SETS];
  logic [`ICACHE_ADDR_W-1:0] reuse_addr [8];
  integer                    seed;
  int                        cycle_cnt = 0;

  icache_cluster u_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .f0_req_i    (f0_req_i),
    .f0_addr_i   (f0_addr_i),
    .f0_rdata_o  (f0_rdata_o),
    .f0_valid_o  (f0_valid_o),
    .f1_req_i    (f1_req_i),
    .f1_addr_i   (f1_addr_i),
    .f1_rdata_o  (f1_rdata_o),
    .f1_valid_o  (f1_valid_o),
    .load_we_i   (load_we_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      report_failure($sformatf("Timeout after %0d cycles, a fetch never finished", cycle_cnt));
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("Mismatch %s: got %h, expected %h", name, actual, expected));
    end
  endtask

  // Half the addresses fall in the first 1 KB so lines get reused
  function automatic logic [31:0] rand_addr();
    logic [31:0] r;
    r = $random(seed);
    if (r[31]) begin
      r = r & 32'h0000_03fc;
    end else begin
      r = r & 32'hffff_fffc;
    end
    return r;
  endfunction

  function automatic logic port_valid(input int port);
    return (port == 0) ? f0_valid_o : f1_valid_o;
  endfunction

  function automatic logic [31:0] port_rdata(input int port);
    return (port == 0) ? f0_rdata_o : f1_rdata_o;
  endfunction

  task automatic drive_fetch(input int port, input logic req, input logic [31:0] addr);
    if (port == 0) begin
      f0_req_i  <= req;
      f0_addr_i <= addr;
    end else begin
      f1_req_i  <= req;
      f1_addr_i <= addr;
    end
  endtask

  // Tag [31:10], index [9:4], word [3:2]; memory ignores bits above 11
  task automatic fetch(input int port, input logic [31:0] addr);
    int                        lat;
    logic                      hit_pred;
    logic [`ICACHE_INDEX_W-1:0] idx;
    logic [`ICACHE_TAG_W-1:0]  tag;
    logic [31:0]               expected;
    lat      = 0;
    idx      = addr[9:4];
    tag      = addr[31:10];
    hit_pred = valid_model[port][idx] && (tag_model[port][idx] == tag);
    expected = mem_model[addr[11:2]];
    @(posedge clk_i);
    drive_fetch(port, 1'b1, addr);
    @(negedge clk_i);
    while (!port_valid(port)) begin
      lat++;
      @(negedge clk_i);
    end
    check_value((port == 0) ? "f0_rdata_o" : "f1_rdata_o", port_rdata(port), expected);
    if (hit_pred && lat != HIT_LAT) begin
      report_failure($sformatf("Hit on port %0d answered after %0d cycles", port, lat));
    end else if (!hit_pred && lat == HIT_LAT) begin
      report_failure($sformatf("Expected miss on port %0d answered like a hit", port));
    end
    tag_model[port][idx]   = tag;
    valid_model[port][idx] = 1'b1;
    @(posedge clk_i);
    drive_fetch(port, 1'b0, addr);
  endtask

  task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    load_we_i   <= 1'b1;
    load_addr_i <= addr;
    load_data_i <= data;
    mem_model[addr[11:2]] = data;
  endtask

  task automatic end_load();
    @(posedge clk_i);
    load_we_i <= 1'b0;
  endtask

  task automatic flush_caches();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      valid_model[0][s] = 1'b0;
      valid_model[1][s] = 1'b0;
    end
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    seed        = 32'h8be3;
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    f0_req_i    = 1'b0;
    f0_addr_i   = '0;
    f1_req_i    = 1'b0;
    f1_addr_i   = '0;
    load_we_i   = 1'b0;
    load_addr_i = '0;
    load_data_i = '0;
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      valid_model[0][s] = 1'b0;
      valid_model[1][s] = 1'b0;
    end
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int w = 0; w < MEM_WORDS; w++) begin
      load_word(w * 4, $random(seed));
    end
    end_load();
    for (int i = 0; i < 200; i++) begin
      fetch(0, rand_addr());
    end

    // Second fetch lands in the line the first one brought in
    for (int i = 0; i < 40; i++) begin
      a = rand_addr();
      b = {a[31:4], a[3:2] ^ 2'($random(seed)), 2'b00};
      fetch(i % 2, a);
      fetch(i % 2, b);
    end

    for (int i = 0; i < 50; i++) begin
      a = $random(seed) & 32'hffff_fffc;
      b = $random(seed) & 32'hffff_fffc;
      fork
        fetch(0, a);
        fetch(1, b);
      join
    end

    a = rand_addr();
    b = a ^ 32'h0000_0c00;  // Same index, other tag and other memory word
    for (int i = 0; i < 10; i++) begin
      fetch(0, a);
      fetch(0, b);
    end

    for (int i = 0; i < 8; i++) begin
      reuse_addr[i] = rand_addr();
      fork
        fetch(0, reuse_addr[i]);
        fetch(1, reuse_addr[i]);
      join
    end
    for (int i = 0; i < 8; i++) begin
      load_word(reuse_addr[i], $random(seed));
    end
    end_load();
    flush_caches();
    for (int i = 0; i < 8; i++) begin
      fork
        fetch(0, reuse_addr[i]);
        fetch(1, reuse_addr[i]);
      join
    end

    repeat (4) @(posedge clk_i);
    $display("All checks passed");
    $finish;
  end

endmodule

/* icache_cluster.f */
+incdir+.
icache_pkg.sv
icache_ram.sv
icache_datapath.sv
icache.sv
imem_arbiter.sv
imem.sv
icache_cluster.sv
tb_icache_cluster.sv

/* Makefile */
TOP = tb_icache_cluster

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f icache_cluster.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f icache_cluster.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
